// File: Bender.yml
package:
  name: blk_accel

sources:
  - include_dirs:
      - include
    files:
      - design/mem_pkg.sv
      - design/ctrl_pkg.sv
      - design/blk_fsm.sv
      - design/word_loader.sv
      - design/word_storer.sv
      - design/mem_arbiter.sv
      - design/block_mixer.sv
      - design/blk_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/blk_sva.sv
      - tests/blk_tb.sv

// File: design/blk_fsm.sv
// ======================================================================
// Job controller FSM: block counter, block buffer, load and store
// address generation, start pulses to the units, busy and done
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "blk_defs.svh"

module blk_fsm (
  input  wire logic               clk,
  input  wire logic               reset_n,
  input  wire logic               start_i,
  input  wire mem_pkg::addr_t     in_addr_i,
  input  wire mem_pkg::addr_t     out_addr_i,
  input  wire ctrl_pkg::len_t     byte_len_i,
  output logic                    load_start_o,
  output mem_pkg::addr_t          load_addr_o,
  input  wire logic               load_done_i,
  input  wire ctrl_pkg::block_t   load_block_i,
  output logic                    mix_start_o,
  output ctrl_pkg::block_t        mix_block_o,
  input  wire logic               mix_done_i,
  input  wire ctrl_pkg::block_t   mix_block_i,
  output logic                    store_start_o,
  output mem_pkg::addr_t          store_addr_o,
  output ctrl_pkg::block_t        store_block_o,
  input  wire logic               store_done_i,
  output logic                    busy_o,
  output logic                    done_o
);

  ctrl_pkg::fsm_state_t state_q, state_d;
  ctrl_pkg::blk_cnt_t   blk_cnt_q;
  ctrl_pkg::blk_cnt_t   blk_total_q;
  ctrl_pkg::block_t     buf_q;
  logic                 busy_q;
  logic                 done_q;
  logic                 start_ok;

  // A new job is taken only once the previous one has fully retired
  assign start_ok = start_i && !busy_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ctrl_pkg::IDLE: begin
        if (start_ok) begin
          if (byte_len_i[`BLK_ADDR_W-1:4] == '0) begin
            state_d = ctrl_pkg::FINISH;
          end else begin
            state_d = ctrl_pkg::LOAD;
          end
        end
      end
      ctrl_pkg::LOAD:       state_d = ctrl_pkg::LOAD_WAIT;
      ctrl_pkg::LOAD_WAIT:  if (load_done_i) state_d = ctrl_pkg::MIX;
      ctrl_pkg::MIX:        state_d = ctrl_pkg::MIX_WAIT;
      ctrl_pkg::MIX_WAIT:   if (mix_done_i) state_d = ctrl_pkg::STORE;
      ctrl_pkg::STORE:      state_d = ctrl_pkg::STORE_WAIT;
      ctrl_pkg::STORE_WAIT: if (store_done_i) state_d = ctrl_pkg::NEXT;
      ctrl_pkg::NEXT: begin
        if (ctrl_pkg::blk_cnt_t'(blk_cnt_q + 1'b1) == blk_total_q) begin
          state_d = ctrl_pkg::FINISH;
        end else begin
          state_d = ctrl_pkg::LOAD;
        end
      end
      ctrl_pkg::FINISH:     state_d = ctrl_pkg::IDLE;
      default:              state_d = ctrl_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q     <= ctrl_pkg::IDLE;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      blk_cnt_q   <= '0;
      blk_total_q <= '0;
    end else begin
      state_q <= state_d;
      done_q  <= (state_q == ctrl_pkg::FINISH);
      // Busy drops the cycle after done
      if (state_q == ctrl_pkg::IDLE && start_ok) begin
        busy_q <= 1'b1;
      end else if (done_q) begin
        busy_q <= 1'b0;
      end
      if (state_q == ctrl_pkg::IDLE && start_ok) begin
        blk_cnt_q   <= '0;
        blk_total_q <= byte_len_i[`BLK_ADDR_W-1:4];
      end else if (state_q == ctrl_pkg::NEXT) begin
        blk_cnt_q <= blk_cnt_q + 1'b1;
      end
    end
  end

  // Block buffer holds the loaded data, then the mixed result
  always_ff @(posedge clk) begin
    if (state_q == ctrl_pkg::LOAD_WAIT && load_done_i) begin
      buf_q <= load_block_i;
    end else if (state_q == ctrl_pkg::MIX_WAIT && mix_done_i) begin
      buf_q <= mix_block_i;
    end
  end

  // Base plus block index times 16
  assign load_addr_o   = in_addr_i + {blk_cnt_q, 4'b0000};
  assign store_addr_o  = out_addr_i + {blk_cnt_q, 4'b0000};

  assign load_start_o  = (state_q == ctrl_pkg::LOAD);
  assign mix_start_o   = (state_q == ctrl_pkg::MIX);
  assign store_start_o = (state_q == ctrl_pkg::STORE);
  assign mix_block_o   = buf_q;
  assign store_block_o = buf_q;
  assign busy_o        = busy_q;
  assign done_o        = done_q;

endmodule

`default_nettype wire

// File: design/blk_top.sv
// ======================================================================
// Block accelerator top: controller, loader, storer, arbiter, mixer
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "blk_defs.svh"

module blk_top (
  input  wire logic             clk,
  input  wire logic             reset_n,
  input  wire logic             start_i,
  input  wire mem_pkg::addr_t   in_addr_i,
  input  wire mem_pkg::addr_t   out_addr_i,
  input  wire ctrl_pkg::len_t   byte_len_i,
  input  wire mem_pkg::word_t   key_i,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output mem_pkg::addr_t        mem_addr_o,
  output mem_pkg::word_t        mem_wdata_o,
  input  wire mem_pkg::word_t   mem_rdata_i,
  output logic                  busy_o,
  output logic                  done_o
);

  logic               load_start, load_done, ld_req, ld_gnt, ld_rvalid;
  logic               mix_start, mix_done;
  logic               store_start, store_done, st_req, st_we, st_gnt;
  mem_pkg::addr_t     load_addr, store_addr, ld_addr, st_addr;
  mem_pkg::word_t     ld_rdata, st_wdata;
  ctrl_pkg::block_t   load_block, mix_in, mix_out, store_block;

  blk_fsm u_fsm (
    .clk, .reset_n, .start_i, .in_addr_i, .out_addr_i, .byte_len_i,
    .load_start_o(load_start), .load_addr_o(load_addr),
    .load_done_i(load_done), .load_block_i(load_block),
    .mix_start_o(mix_start), .mix_block_o(mix_in),
    .mix_done_i(mix_done), .mix_block_i(mix_out),
    .store_start_o(store_start), .store_addr_o(store_addr),
    .store_block_o(store_block), .store_done_i(store_done),
    .busy_o, .done_o
  );

  word_loader u_loader (
    .clk, .reset_n, .start_i(load_start), .base_i(load_addr),
    .req_o(ld_req), .addr_o(ld_addr), .gnt_i(ld_gnt),
    .rvalid_i(ld_rvalid), .rdata_i(ld_rdata),
    .done_o(load_done), .block_o(load_block)
  );

  word_storer u_storer (
    .clk, .reset_n, .start_i(store_start), .base_i(store_addr),
    .block_i(store_block), .req_o(st_req), .we_o(st_we),
    .addr_o(st_addr), .wdata_o(st_wdata), .gnt_i(st_gnt), .done_o(store_done)
  );

  mem_arbiter u_arb (
    .clk, .reset_n,
    .ld_req_i(ld_req), .ld_addr_i(ld_addr), .ld_gnt_o(ld_gnt),
    .ld_rvalid_o(ld_rvalid), .ld_rdata_o(ld_rdata),
    .st_req_i(st_req), .st_we_i(st_we), .st_addr_i(st_addr),
    .st_wdata_i(st_wdata), .st_gnt_o(st_gnt),
    .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o, .mem_rdata_i
  );

  block_mixer u_mixer (
    .clk, .reset_n, .start_i(mix_start), .block_i(mix_in), .key_i,
    .done_o(mix_done), .block_o(mix_out)
  );

endmodule

`default_nettype wire

// File: design/block_mixer.sv
// ======================================================================
// Keyed mixing engine: one rotate-and-xor round per cycle
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "blk_defs.svh"

module block_mixer (
  input  wire logic             clk,
  input  wire logic             reset_n,
  input  wire logic             start_i,
  input  wire ctrl_pkg::block_t block_i,
  input  wire mem_pkg::word_t   key_i,
  output logic                  done_o,
  output ctrl_pkg::block_t      block_o
);

  localparam int unsigned       W     = `BLK_WORD_W;
  localparam int unsigned       CNT_W = $clog2(`BLK_ROUNDS);
  localparam logic [CNT_W-1:0]  LAST  = CNT_W'(`BLK_ROUNDS - 1);

  logic               active;
  logic [CNT_W-1:0]   rnd_cnt;
  logic               done_q;
  ctrl_pkg::block_t   state_q;

  // Word i becomes rol8(w[i] ^ key) ^ w[i+1], indices wrap
  function automatic ctrl_pkg::block_t mix_round(input ctrl_pkg::block_t b,
                                                 input mem_pkg::word_t k);
    ctrl_pkg::block_t r;
    mem_pkg::word_t   x;
    int               i;
    r = '0;
    for (i = 0; i < `BLK_WORDS; i++) begin
      x = b[i*W +: W] ^ k;
      r[i*W +: W] = {x[W-9:0], x[W-1:W-8]} ^ b[((i + 1) % `BLK_WORDS)*W +: W];
    end
    return r;
  endfunction

  // First round is taken on the start edge
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      active  <= 1'b0;
      rnd_cnt <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        active  <= 1'b1;
        rnd_cnt <= CNT_W'(1);
      end else if (active) begin
        rnd_cnt <= rnd_cnt + 1'b1;
        if (rnd_cnt == LAST) begin
          active <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      state_q <= mix_round(block_i, key_i);
    end else if (active) begin
      state_q <= mix_round(state_q, key_i);
    end
  end

  assign done_o  = done_q;
  assign block_o = state_q;

endmodule

`default_nettype wire

// File: design/ctrl_pkg.sv
// ======================================================================
// Controller-side types: FSM states, block vector, byte length and
// block counter
// ======================================================================
`default_nettype none

`include "blk_defs.svh"

package ctrl_pkg;

  // Word 0 of a block sits in the low bits
  typedef logic [`BLK_WORD_W*`BLK_WORDS-1:0] block_t;
  typedef logic [`BLK_ADDR_W-1:0]            len_t;
  // Byte length divided by 16
  typedef logic [`BLK_ADDR_W-5:0]            blk_cnt_t;

  typedef enum logic [3:0] {
    IDLE, LOAD, LOAD_WAIT, MIX, MIX_WAIT, STORE, STORE_WAIT, NEXT, FINISH
  } fsm_state_t;

endpackage

`default_nettype wire

// File: design/mem_arbiter.sv
// ======================================================================
// Fixed-priority memory arbiter, storer over loader, with read-return
// steering back to the loader
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "blk_defs.svh"

module mem_arbiter (
  input  wire logic             clk,
  input  wire logic             reset_n,
  input  wire logic             ld_req_i,
  input  wire mem_pkg::addr_t   ld_addr_i,
  output logic                  ld_gnt_o,
  output logic                  ld_rvalid_o,
  output mem_pkg::word_t        ld_rdata_o,
  input  wire logic             st_req_i,
  input  wire logic             st_we_i,
  input  wire mem_pkg::addr_t   st_addr_i,
  input  wire mem_pkg::word_t   st_wdata_i,
  output logic                  st_gnt_o,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output mem_pkg::addr_t        mem_addr_o,
  output mem_pkg::word_t        mem_wdata_o,
  input  wire mem_pkg::word_t   mem_rdata_i
);

  logic ld_rd_pend;

  // Storer always wins a tie
  assign st_gnt_o    = st_req_i;
  assign ld_gnt_o    = ld_req_i && !st_req_i;

  assign mem_req_o   = st_req_i || ld_req_i;
  assign mem_we_o    = st_req_i && st_we_i;
  assign mem_addr_o  = st_req_i ? st_addr_i : ld_addr_i;
  assign mem_wdata_o = st_wdata_i;

  // Loader read in flight, data comes back next cycle
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ld_rd_pend <= 1'b0;
    end else begin
      ld_rd_pend <= ld_gnt_o;
    end
  end

  assign ld_rvalid_o = ld_rd_pend;
  assign ld_rdata_o  = mem_rdata_i;

endmodule

`default_nettype wire

// File: design/mem_pkg.sv
// ======================================================================
// Memory-side types: data word and byte address
// ======================================================================
`default_nettype none

`include "blk_defs.svh"

package mem_pkg;

  typedef logic [`BLK_WORD_W-1:0] word_t;
  typedef logic [`BLK_ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// File: design/word_loader.sv
// ======================================================================
// Block loader: word reads through the arbiter, block assembly
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "blk_defs.svh"

module word_loader (
  input  wire logic             clk,
  input  wire logic             reset_n,
  input  wire logic             start_i,
  input  wire mem_pkg::addr_t   base_i,
  output logic                  req_o,
  output mem_pkg::addr_t        addr_o,
  input  wire logic             gnt_i,
  input  wire logic             rvalid_i,
  input  wire mem_pkg::word_t   rdata_i,
  output logic                  done_o,
  output ctrl_pkg::block_t      block_o
);

  localparam int unsigned          CNT_W = $clog2(`BLK_WORDS);
  localparam logic [CNT_W-1:0]     LAST  = CNT_W'(`BLK_WORDS - 1);

  logic                 issue_act;
  logic [CNT_W-1:0]     issue_cnt;
  logic [CNT_W-1:0]     ret_cnt;
  logic                 done_q;
  mem_pkg::addr_t       base_q;
  ctrl_pkg::block_t     block_q;

  // First read goes out in the start cycle itself
  assign req_o  = start_i || issue_act;
  assign addr_o = start_i ? base_i : base_q + mem_pkg::addr_t'({issue_cnt, 2'b00});

  // Counters wrap back to zero after the last word
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      issue_act <= 1'b0;
      issue_cnt <= '0;
      ret_cnt   <= '0;
      done_q    <= 1'b0;
    end else begin
      if (start_i) begin
        issue_act <= 1'b1;
      end
      if (req_o && gnt_i) begin
        issue_cnt <= issue_cnt + 1'b1;
        if (issue_cnt == LAST) begin
          issue_act <= 1'b0;
        end
      end
      if (rvalid_i) begin
        ret_cnt <= ret_cnt + 1'b1;
      end
      done_q <= rvalid_i && (ret_cnt == LAST);
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      base_q <= base_i;
    end
    if (rvalid_i) begin
      block_q[ret_cnt*`BLK_WORD_W +: `BLK_WORD_W] <= rdata_i;
    end
  end

  assign done_o  = done_q;
  assign block_o = block_q;

endmodule

`default_nettype wire

// File: design/word_storer.sv
// ======================================================================
// Block storer: four word writes through the arbiter
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "blk_defs.svh"

module word_storer (
  input  wire logic             clk,
  input  wire logic             reset_n,
  input  wire logic             start_i,
  input  wire mem_pkg::addr_t   base_i,
  input  wire ctrl_pkg::block_t block_i,
  output logic                  req_o,
  output logic                  we_o,
  output mem_pkg::addr_t        addr_o,
  output mem_pkg::word_t        wdata_o,
  input  wire logic             gnt_i,
  output logic                  done_o
);

  localparam int unsigned       CNT_W = $clog2(`BLK_WORDS);
  localparam logic [CNT_W-1:0]  LAST  = CNT_W'(`BLK_WORDS - 1);

  logic               active;
  logic [CNT_W-1:0]   idx;
  logic               done_q;
  mem_pkg::addr_t     base_q;
  ctrl_pkg::block_t   block_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      active <= 1'b0;
      idx    <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        active <= 1'b1;
        idx    <= '0;
      end else if (active && gnt_i) begin
        idx <= idx + 1'b1;
        if (idx == LAST) begin
          active <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      base_q  <= base_i;
      block_q <= block_i;
    end
  end

  // Only writes are issued
  assign req_o   = active;
  assign we_o    = active;
  assign addr_o  = base_q + mem_pkg::addr_t'({idx, 2'b00});
  assign wdata_o = block_q[idx*`BLK_WORD_W +: `BLK_WORD_W];
  assign done_o  = done_q;

endmodule

`default_nettype wire

// File: files.f
+incdir+include
design/mem_pkg.sv
design/ctrl_pkg.sv
design/blk_fsm.sv
design/word_loader.sv
design/word_storer.sv
design/mem_arbiter.sv
design/block_mixer.sv
design/blk_top.sv
tests/blk_sva.sv
tests/blk_tb.sv

// File: include/blk_defs.svh
// ======================================================================
// Block accelerator defines: word and address widths, block size in
// words and number of mixer rounds per block
// ======================================================================

`ifndef BLK_DEFS_SVH
`define BLK_DEFS_SVH

// Memory word and byte address widths
`define BLK_WORD_W 32
`define BLK_ADDR_W 32

// Words in one 16-byte block
`define BLK_WORDS  4

// Mixer rounds applied to each block
`define BLK_ROUNDS 4

`endif

// File: tests/blk_sva.sv
// ======================================================================
// Bound assertions: memory port strobes, done pulse, busy release
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module blk_sva (
  input wire logic clk,
  input wire logic reset_n,
  input wire logic mem_req_i,
  input wire logic mem_we_i,
  input wire logic busy_i,
  input wire logic done_i
);

  int unsigned fail_cnt = 0;

  we_with_req: assert property (@(posedge clk) disable iff (!reset_n)
    mem_we_i |-> mem_req_i)
    else begin
      fail_cnt++;
      $error("mem_we_o high without mem_req_o");
    end

  done_single: assert property (@(posedge clk) disable iff (!reset_n)
    done_i |=> !done_i)
    else begin
      fail_cnt++;
      $error("done_o held for more than one cycle");
    end

  // Busy covers the done cycle and drops right after it
  busy_release: assert property (@(posedge clk) disable iff (!reset_n)
    done_i |-> busy_i ##1 !busy_i)
    else begin
      fail_cnt++;
      $error("busy_o did not fall one cycle after done_o");
    end

  busy_fall_cause: assert property (@(posedge clk) disable iff (!reset_n)
    $fell(busy_i) |-> $past(done_i))
    else begin
      fail_cnt++;
      $error("busy_o fell without a done_o pulse before it");
    end

  req_while_busy: assert property (@(posedge clk) disable iff (!reset_n)
    mem_req_i |-> busy_i)
    else begin
      fail_cnt++;
      $error("memory request while the accelerator is idle");
    end

endmodule

bind blk_top blk_sva u_sva (
  .clk, .reset_n,
  .mem_req_i(mem_req_o), .mem_we_i(mem_we_o),
  .busy_i(busy_o), .done_i(done_o)
);

`default_nettype wire

// File: tests/blk_tb.sv
// ======================================================================
// Block accelerator testbench: clock, reset, memory model, job
// stimulus, reference mixing function and memory image comparison
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "blk_defs.svh"

module blk_tb;

  localparam int MEM_WORDS   = 256;
  localparam int IDX_W       = $clog2(MEM_WORDS);
  localparam int CYC_PER_BLK = 24;
  // 11 blocks over 4 jobs plus setup per job, doubled for margin
  localparam int CYC_LIMIT   = 2 * (11 * CYC_PER_BLK + 4 * 40 + 20);

  logic               clk;
  logic               reset_n;
  logic               start_i;
  mem_pkg::addr_t     in_addr_i;
  mem_pkg::addr_t     out_addr_i;
  ctrl_pkg::len_t     byte_len_i;
  mem_pkg::word_t     key_i;
  logic               mem_req_o;
  logic               mem_we_o;
  mem_pkg::addr_t     mem_addr_o;
  mem_pkg::word_t     mem_wdata_o;
  mem_pkg::word_t     mem_rdata_i;
  logic               busy_o;
  logic               done_o;

  mem_pkg::word_t     mem     [MEM_WORDS];
  mem_pkg::word_t     exp_mem [MEM_WORDS];
  integer             seed;
  int                 cycles;
  int                 checks;
  int                 errors;
  int                 done_cnt;
  int                 req_cnt;

  blk_top dut_i (
    .clk, .reset_n, .start_i, .in_addr_i, .out_addr_i, .byte_len_i, .key_i,
    .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o, .mem_rdata_i,
    .busy_o, .done_o
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYC_LIMIT) begin
      $display("Timeout: the jobs did not finish within %0d cycles", CYC_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Single-port memory, read data valid the cycle after the request
  always @(posedge clk) begin
    if (mem_req_o) begin
      req_cnt <= req_cnt + 1;
      assert (mem_addr_o < MEM_WORDS * 4) else begin
        errors++;
        $display("Memory access outside the model at address %h", mem_addr_o);
      end
      if (mem_we_o) begin
        mem[mem_addr_o[2 +: IDX_W]] <= mem_wdata_o;
      end else begin
        mem_rdata_i <= mem[mem_addr_o[2 +: IDX_W]];
      end
    end
  end

  // Whole memory image is compared after every done pulse
  always @(posedge clk) begin : compare_mem
    int i;
    if (done_o) begin
      done_cnt <= done_cnt + 1;
      for (i = 0; i < MEM_WORDS; i++) begin
        checks++;
        assert (mem[i] === exp_mem[i]) else begin
          errors++;
          $display("FAIL mem[%h]: got %h, expected %h", i * 4, mem[i], exp_mem[i]);
        end
      end
    end
  end

  function automatic mem_pkg::word_t fill_word(input mem_pkg::addr_t byte_addr);
    return {byte_addr[15:0] ^ 16'hc5a3, byte_addr[15:0] ^ byte_addr[31:16]};
  endfunction

  // Expected block after all rounds of the keyed mix
  function automatic ctrl_pkg::block_t ref_mix(input ctrl_pkg::block_t blk,
                                               input mem_pkg::word_t key);
    mem_pkg::word_t   w   [`BLK_WORDS];
    mem_pkg::word_t   nxt [`BLK_WORDS];
    mem_pkg::word_t   t;
    ctrl_pkg::block_t res;
    int               r;
    int               i;
    for (i = 0; i < `BLK_WORDS; i++) begin
      w[i] = blk[i*`BLK_WORD_W +: `BLK_WORD_W];
    end
    for (r = 0; r < `BLK_ROUNDS; r++) begin
      for (i = 0; i < `BLK_WORDS; i++) begin
        t      = w[i] ^ key;
        nxt[i] = ((t << 8) | (t >> (`BLK_WORD_W - 8))) ^ w[(i + 1) % `BLK_WORDS];
      end
      w = nxt;
    end
    for (i = 0; i < `BLK_WORDS; i++) begin
      res[i*`BLK_WORD_W +: `BLK_WORD_W] = w[i];
    end
    return res;
  endfunction

  // Random source data, written to the model and the expected image
  task automatic load_blocks(input mem_pkg::addr_t src, input int nblk);
    mem_pkg::word_t d;
    int             k;
    for (k = 0; k < nblk * `BLK_WORDS; k++) begin
      d = $random(seed);
      mem[src[2 +: IDX_W] + k]     = d;
      exp_mem[src[2 +: IDX_W] + k] = d;
    end
  endtask

  task automatic expect_blocks(input mem_pkg::addr_t src, input mem_pkg::addr_t dst,
                               input int nblk, input mem_pkg::word_t key);
    ctrl_pkg::block_t blk;
    int               b;
    int               j;
    int               si;
    int               di;
    for (b = 0; b < nblk; b++) begin
      si = src[2 +: IDX_W] + b * `BLK_WORDS;
      di = dst[2 +: IDX_W] + b * `BLK_WORDS;
      for (j = 0; j < `BLK_WORDS; j++) begin
        blk[j*`BLK_WORD_W +: `BLK_WORD_W] = exp_mem[si + j];
      end
      blk = ref_mix(blk, key);
      for (j = 0; j < `BLK_WORDS; j++) begin
        exp_mem[di + j] = blk[j*`BLK_WORD_W +: `BLK_WORD_W];
      end
    end
  endtask

  // Runs one job; with hold_start set, start_i stays high while it is busy
  task automatic run_job(input mem_pkg::addr_t src, input mem_pkg::addr_t dst,
                         input ctrl_pkg::len_t len, input mem_pkg::word_t key,
                         input bit hold_start, output int lat);
    int nblk;
    nblk = len >> 4;
    // Source and expected image change one edge after the last done compare
    @(posedge clk);
    load_blocks(src, nblk);
    expect_blocks(src, dst, nblk, key);
    start_i    <= 1'b1;
    in_addr_i  <= src;
    out_addr_i <= dst;
    byte_len_i <= len;
    key_i      <= key;
    @(posedge clk);
    start_i <= 1'b0;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      // Held start also covers the done cycle with the FSM back in IDLE
      start_i <= hold_start && busy_o && !done_o;
    end while (!done_o);
    start_i <= 1'b0;
  endtask

  initial begin
    int lat;
    int req_before;
    int sva_fails;
    int i;
    seed        = 32'h603ee045;
    reset_n     = 1'b0;
    start_i     = 1'b0;
    in_addr_i   = '0;
    out_addr_i  = '0;
    byte_len_i  = '0;
    key_i       = '0;
    mem_rdata_i = '0;
    cycles      = 0;
    checks      = 0;
    errors      = 0;
    done_cnt    = 0;
    req_cnt     = 0;
    for (i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = fill_word(i * 4);
      exp_mem[i] = mem[i];
    end
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;

    // One block with a fixed key
    run_job(32'h000, 32'h100, 32'd16, 32'h0123_4567, 1'b0, lat);
    // Eight blocks, random key, low length bits set
    run_job(32'h040, 32'h200, 32'd133, $random(seed), 1'b0, lat);

    // Length below one block
    req_before = req_cnt;
    run_job(32'h380, 32'h3c0, 32'd12, 32'h0, 1'b0, lat);
    checks += 2;
    assert (lat == 2) else begin
      errors++;
      $display("FAIL done_o latency: got %h, expected %h", lat, 2);
    end
    assert (req_cnt == req_before) else begin
      errors++;
      $display("FAIL mem_req_o count: got %h, expected %h", req_cnt, req_before);
    end

    // Two blocks with start held high while busy
    run_job(32'h300, 32'h340, 32'd32, $random(seed), 1'b1, lat);
    repeat (12) @(posedge clk);
    checks += 2;
    assert (done_cnt == 4) else begin
      errors++;
      $display("FAIL done_o count: got %h, expected %h", done_cnt, 4);
    end
    assert (!busy_o) else begin
      errors++;
      $display("The accelerator is still busy after the last job");
    end

    sva_fails = dut_i.u_sva.fail_cnt;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
